/* mempool_pkg.sv */
/*
 * Shared definitions for the MemPool group
 * Bank geometry, TCDM request and response structs, DMA types and states
 */
package mempool_pkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int unsigned NumTiles      = 4;
  localparam int unsigned TileSelWidth  = 2;
  localparam int unsigned RowWidth      = 6;
  localparam int unsigned NumRows       = 2 ** RowWidth;
  // Row over tile select
  localparam int unsigned TcdmAddrWidth = RowWidth + TileSelWidth;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned IniWidth      = 2;
  localparam int unsigned DmaLenWidth   = 9;
  // Up to NumRows words per tile
  localparam int unsigned DmaCntWidth   = RowWidth + 1;

  // ------------------------------------------------------------------------
  // TCDM
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [TcdmAddrWidth-1:0] addr;
    logic                     write;
    logic [DataWidth-1:0]     wdata;
    logic [BeWidth-1:0]       be;
  } tcdm_req_t;

  typedef struct packed {
    logic [RowWidth-1:0]  row;
    logic [IniWidth-1:0]  ini;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } bank_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic [IniWidth-1:0]  ini;
  } bank_resp_t;

  // ------------------------------------------------------------------------
  // DMA
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [TcdmAddrWidth-1:0] start_addr;
    logic [DmaLenWidth-1:0]   len;
    logic [DataWidth-1:0]     value;
  } dma_req_t;

  typedef struct packed {
    logic [RowWidth-1:0]    row;
    logic [DmaCntWidth-1:0] count;
    logic [DataWidth-1:0]   value;
  } dma_tile_cmd_t;

  typedef struct packed {
    logic backend_idle;
    logic trans_complete;
  } dma_meta_t;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_DISPATCH,
    DMA_WAIT
  } dma_state_e;

  typedef enum logic {
    ENG_IDLE,
    ENG_WRITE
  } engine_state_e;

endpackage

/* tcdm_bank.sv */
/*
 * TCDM bank of one tile, byte-masked writes and synchronous read
 * Interconnect traffic has priority over DMA writes
 */
`timescale 1ns/1ns

module tcdm_bank
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  // Interconnect port
  input  bank_req_t            req_i,
  input  logic                 req_valid_i,
  output bank_resp_t           resp_o,
  output logic                 resp_valid_o,
  // DMA write port
  input  logic [RowWidth-1:0]  dma_row_i,
  input  logic [DataWidth-1:0] dma_wdata_i,
  input  logic                 dma_valid_i,
  output logic                 dma_gnt_o
);

  logic [DataWidth-1:0] mem_q [NumRows];

  logic                 wr_en;
  logic [RowWidth-1:0]  wr_row;
  logic [DataWidth-1:0] wr_data;
  logic [BeWidth-1:0]   wr_be;
  logic                 rd_en;

  // DMA only gets the bank when the interconnect leaves it free
  assign dma_gnt_o = dma_valid_i && !req_valid_i;
  assign rd_en     = req_valid_i && !req_i.write;

  always_comb begin
    if (req_valid_i) begin
      wr_en   = req_i.write;
      wr_row  = req_i.row;
      wr_data = req_i.wdata;
      wr_be   = req_i.be;
    end else begin
      wr_en   = dma_valid_i;
      wr_row  = dma_row_i;
      wr_data = dma_wdata_i;
      wr_be   = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (wr_be[i]) begin
          mem_q[wr_row][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // Read data and tag for the response
  always_ff @(posedge clk_i) begin
    resp_valid_o <= rd_en;
    if (rd_en) begin
      resp_o.rdata <= mem_q[req_i.row];
      resp_o.ini   <= req_i.ini;
    end
  end

endmodule

/* tcdm_local_xbar.sv */
/*
 * Local TCDM interconnect: tile requests to word-interleaved banks,
 * round-robin arbitration per bank, read data steered back by tag
 */
`timescale 1ns/1ns

module tcdm_local_xbar
  import mempool_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // Masters
  input  tcdm_req_t  [NumTiles-1:0]                req_i,
  input  logic       [NumTiles-1:0]                req_valid_i,
  output logic       [NumTiles-1:0]                req_ready_o,
  // Banks
  output bank_req_t  [NumTiles-1:0]                bank_req_o,
  output logic       [NumTiles-1:0]                bank_req_valid_o,
  input  bank_resp_t [NumTiles-1:0]                bank_resp_i,
  input  logic       [NumTiles-1:0]                bank_resp_valid_i,
  // Read responses
  output logic       [NumTiles-1:0][DataWidth-1:0] resp_rdata_o,
  output logic       [NumTiles-1:0]                resp_valid_o
);

  logic [NumTiles-1:0][TileSelWidth-1:0] tgt_bank;
  // Indexed [bank][master]
  logic [NumTiles-1:0][NumTiles-1:0]     bank_reqs;
  logic [NumTiles-1:0][NumTiles-1:0]     bank_gnt;

  for (genvar m = 0; m < NumTiles; m++) begin : gen_master
    assign tgt_bank[m]    = req_i[m].addr[TileSelWidth-1:0];
    assign req_ready_o[m] = bank_gnt[tgt_bank[m]][m];
  end

  // ------------------------------------------------------------------------
  // Per-bank arbitration
  // ------------------------------------------------------------------------
  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank
    logic [IniWidth-1:0] winner;
    logic [IniWidth-1:0] rr_q;

    for (genvar m = 0; m < NumTiles; m++) begin : gen_req
      assign bank_reqs[b][m] = req_valid_i[m] && (tgt_bank[m] == TileSelWidth'(b));
      assign bank_gnt[b][m]  = bank_reqs[b][m] && (winner == IniWidth'(m));
    end

    // First requester at or after the pointer
    always_comb begin
      logic [IniWidth-1:0] idx;
      winner = rr_q;
      for (int i = NumTiles - 1; i >= 0; i--) begin
        idx = rr_q + IniWidth'(i);
        if (bank_reqs[b][idx]) begin
          winner = idx;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rr_q <= '0;
      end else if (bank_req_valid_o[b]) begin
        rr_q <= winner + IniWidth'(1);
      end
    end

    assign bank_req_valid_o[b] = |bank_reqs[b];
    assign bank_req_o[b] = '{
      row:   req_i[winner].addr[TcdmAddrWidth-1:TileSelWidth],
      ini:   winner,
      write: req_i[winner].write,
      wdata: req_i[winner].wdata,
      be:    req_i[winner].be
    };
  end

  // ------------------------------------------------------------------------
  // Response steering
  // ------------------------------------------------------------------------
  // A master wins at most one bank per cycle, so tags never collide
  always_comb begin
    resp_valid_o = '0;
    resp_rdata_o = '0;
    for (int b = 0; b < NumTiles; b++) begin
      if (bank_resp_valid_i[b]) begin
        resp_valid_o[bank_resp_i[b].ini] = 1'b1;
        resp_rdata_o[bank_resp_i[b].ini] = bank_resp_i[b].rdata;
      end
    end
  end

endmodule

/* dma_tile_engine.sv */
/*
 * Per-tile DMA engine, writes its share of a fill burst into the bank
 */
`timescale 1ns/1ns

module dma_tile_engine
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  dma_tile_cmd_t        cmd_i,
  input  logic                 start_i,
  output logic                 idle_o,
  output logic [RowWidth-1:0]  row_o,
  output logic [DataWidth-1:0] wdata_o,
  output logic                 valid_o,
  input  logic                 gnt_i
);

  engine_state_e          state_q;
  logic [RowWidth-1:0]    row_q;
  logic [DmaCntWidth-1:0] cnt_q;
  logic [DataWidth-1:0]   value_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ENG_IDLE;
    end else begin
      case (state_q)
        ENG_IDLE:  if (start_i) state_q <= ENG_WRITE;
        ENG_WRITE: if (gnt_i && cnt_q == DmaCntWidth'(1)) state_q <= ENG_IDLE;
        default:   state_q <= ENG_IDLE;
      endcase
    end
  end

  // Rows wrap inside the bank, values step over the other tiles
  always_ff @(posedge clk_i) begin
    if (state_q == ENG_IDLE && start_i) begin
      row_q   <= cmd_i.row;
      cnt_q   <= cmd_i.count;
      value_q <= cmd_i.value;
    end else if (state_q == ENG_WRITE && gnt_i) begin
      row_q   <= row_q + RowWidth'(1);
      cnt_q   <= cnt_q - DmaCntWidth'(1);
      value_q <= value_q + DataWidth'(NumTiles);
    end
  end

  assign idle_o  = (state_q == ENG_IDLE);
  assign valid_o = (state_q == ENG_WRITE);
  assign row_o   = row_q;
  assign wdata_o = value_q;

endmodule

/* dma_midend.sv */
/*
 * Distributed DMA midend: one-entry request register, split of a fill
 * burst into per-tile commands and the registered DMA status
 */
`timescale 1ns/1ns

module dma_midend
  import mempool_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  // Burst request
  input  dma_req_t                       dma_req_i,
  input  logic                           dma_req_valid_i,
  output logic                           dma_req_ready_o,
  // Tile engines
  output dma_tile_cmd_t [NumTiles-1:0]   tile_cmd_o,
  output logic          [NumTiles-1:0]   tile_start_o,
  input  logic          [NumTiles-1:0]   tile_idle_i,
  // Status
  output dma_meta_t                      dma_meta_o
);

  dma_state_e state_q;
  dma_req_t   req_q;
  logic       req_full_q;
  logic       all_idle;
  dma_meta_t  meta_d;

  assign all_idle        = &tile_idle_i;
  assign dma_req_ready_o = !req_full_q;

  // ------------------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (dma_req_valid_i && dma_req_ready_o) begin
      req_q <= dma_req_i;
    end
  end

  // ------------------------------------------------------------------------
  // Burst split
  // ------------------------------------------------------------------------
  for (genvar t = 0; t < NumTiles; t++) begin : gen_split
    logic [TileSelWidth-1:0]  offset;
    logic [DmaLenWidth-1:0]   span;
    logic [TcdmAddrWidth-1:0] first_addr;
    logic [DmaCntWidth-1:0]   count;

    // Index of the first burst word that lands on this tile
    assign offset     = TileSelWidth'(t) - req_q.start_addr[TileSelWidth-1:0];
    assign span       = req_q.len - DmaLenWidth'(offset) - DmaLenWidth'(1);
    assign first_addr = req_q.start_addr + TcdmAddrWidth'(offset);
    assign count      = (req_q.len > DmaLenWidth'(offset)) ?
                        DmaCntWidth'(span >> TileSelWidth) + DmaCntWidth'(1) : '0;

    assign tile_cmd_o[t] = '{
      row:   first_addr[TcdmAddrWidth-1:TileSelWidth],
      count: count,
      value: req_q.value + DataWidth'(offset)
    };
    assign tile_start_o[t] = (state_q == DMA_DISPATCH) && (count != '0);
  end

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= DMA_IDLE;
      req_full_q <= 1'b0;
    end else begin
      case (state_q)
        DMA_IDLE:     if (req_full_q) state_q <= DMA_DISPATCH;
        DMA_DISPATCH: state_q <= DMA_WAIT;
        DMA_WAIT:     if (all_idle) state_q <= DMA_IDLE;
        default:      state_q <= DMA_IDLE;
      endcase
      // Ready is low in DISPATCH, so load and release never meet
      if (dma_req_valid_i && dma_req_ready_o) begin
        req_full_q <= 1'b1;
      end else if (state_q == DMA_DISPATCH) begin
        req_full_q <= 1'b0;
      end
    end
  end

  always_comb begin
    meta_d.trans_complete = (state_q == DMA_WAIT) && all_idle;
    meta_d.backend_idle   = (state_q == DMA_IDLE) && !req_full_q && all_idle;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dma_meta_o <= '{backend_idle: 1'b1, trans_complete: 1'b0};
    end else begin
      dma_meta_o <= meta_d;
    end
  end

endmodule

/* mempool_group.sv */
/*
 * MemPool group top level: local interconnect, four TCDM banks,
 * DMA midend and one DMA engine per tile
 */
`timescale 1ns/1ns

module mempool_group
  import mempool_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  // Tile request ports
  input  tcdm_req_t [NumTiles-1:0]                tile_req_i,
  input  logic      [NumTiles-1:0]                tile_req_valid_i,
  output logic      [NumTiles-1:0]                tile_req_ready_o,
  output logic      [NumTiles-1:0][DataWidth-1:0] tile_resp_rdata_o,
  output logic      [NumTiles-1:0]                tile_resp_valid_o,
  // DMA
  input  dma_req_t                                dma_req_i,
  input  logic                                    dma_req_valid_i,
  output logic                                    dma_req_ready_o,
  output dma_meta_t                               dma_meta_o
);

  bank_req_t     [NumTiles-1:0]                bank_req;
  logic          [NumTiles-1:0]                bank_req_valid;
  bank_resp_t    [NumTiles-1:0]                bank_resp;
  logic          [NumTiles-1:0]                bank_resp_valid;
  dma_tile_cmd_t [NumTiles-1:0]                tile_cmd;
  logic          [NumTiles-1:0]                tile_start;
  logic          [NumTiles-1:0]                tile_idle;
  logic          [NumTiles-1:0][RowWidth-1:0]  eng_row;
  logic          [NumTiles-1:0][DataWidth-1:0] eng_wdata;
  logic          [NumTiles-1:0]                eng_valid;
  logic          [NumTiles-1:0]                eng_gnt;

  tcdm_local_xbar i_local_xbar (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .req_i            (tile_req_i       ),
    .req_valid_i      (tile_req_valid_i ),
    .req_ready_o      (tile_req_ready_o ),
    .bank_req_o       (bank_req         ),
    .bank_req_valid_o (bank_req_valid   ),
    .bank_resp_i      (bank_resp        ),
    .bank_resp_valid_i(bank_resp_valid  ),
    .resp_rdata_o     (tile_resp_rdata_o),
    .resp_valid_o     (tile_resp_valid_o)
  );

  dma_midend i_dma_midend (
    .clk_i          (clk_i          ),
    .reset_i        (reset_i        ),
    .dma_req_i      (dma_req_i      ),
    .dma_req_valid_i(dma_req_valid_i),
    .dma_req_ready_o(dma_req_ready_o),
    .tile_cmd_o     (tile_cmd       ),
    .tile_start_o   (tile_start     ),
    .tile_idle_i    (tile_idle      ),
    .dma_meta_o     (dma_meta_o     )
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    tcdm_bank i_bank (
      .clk_i       (clk_i             ),
      .req_i       (bank_req[t]       ),
      .req_valid_i (bank_req_valid[t] ),
      .resp_o      (bank_resp[t]      ),
      .resp_valid_o(bank_resp_valid[t]),
      .dma_row_i   (eng_row[t]        ),
      .dma_wdata_i (eng_wdata[t]      ),
      .dma_valid_i (eng_valid[t]      ),
      .dma_gnt_o   (eng_gnt[t]        )
    );

    dma_tile_engine i_engine (
      .clk_i  (clk_i        ),
      .reset_i(reset_i      ),
      .cmd_i  (tile_cmd[t]  ),
      .start_i(tile_start[t]),
      .idle_o (tile_idle[t] ),
      .row_o  (eng_row[t]   ),
      .wdata_o(eng_wdata[t] ),
      .valid_o(eng_valid[t] ),
      .gnt_i  (eng_gnt[t]   )
    );
  end

endmodule

/* mempool_group_properties.sv */
/*
 * Concurrent checks on the group top level: read response timing
 * and the DMA completion pulse
 */
`timescale 1ns/1ns

module mempool_group_properties
  import mempool_pkg::*;
(
  input logic                     clk_i,
  input logic                     reset_i,
  input tcdm_req_t [NumTiles-1:0] tile_req_i,
  input logic [NumTiles-1:0]      tile_req_valid_i,
  input logic [NumTiles-1:0]      tile_req_ready_o,
  input logic [NumTiles-1:0]      tile_resp_valid_o,
  input dma_meta_t                dma_meta_o
);

  logic [NumTiles-1:0] rd_acc;
  // Number of failed assertions
  int unsigned         fail_count = 0;

  for (genvar m = 0; m < NumTiles; m++) begin : gen_master
    assign rd_acc[m] = tile_req_valid_i[m] && tile_req_ready_o[m] && !tile_req_i[m].write;

    resp_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
      rd_acc[m] |=> tile_resp_valid_o[m])
      else begin
        $error("Master %0d read accepted but no response followed", m);
        fail_count++;
      end

    resp_needs_read: assert property (@(posedge clk_i) disable iff (reset_i)
      tile_resp_valid_o[m] |-> $past(rd_acc[m]))
      else begin
        $error("Master %0d response without a read in the cycle before", m);
        fail_count++;
      end
  end

  complete_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_meta_o.trans_complete |=> !dma_meta_o.trans_complete)
    else begin
      $error("trans_complete lasted more than one cycle");
      fail_count++;
    end

  complete_not_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !(dma_meta_o.trans_complete && dma_meta_o.backend_idle))
    else begin
      $error("trans_complete while backend_idle is high");
      fail_count++;
    end

endmodule

bind mempool_group mempool_group_properties i_properties (
  .clk_i            (clk_i            ),
  .reset_i          (reset_i          ),
  .tile_req_i       (tile_req_i       ),
  .tile_req_valid_i (tile_req_valid_i ),
  .tile_req_ready_o (tile_req_ready_o ),
  .tile_resp_valid_o(tile_resp_valid_o),
  .dma_meta_o       (dma_meta_o       )
);

/* tb_mempool_group.sv */
/*
 * Testbench for the MemPool group, runs the golden command file
 * against a byte-level memory model and checks reads and DMA status
 */
`timescale 1ns/1ns

module tb_mempool_group
  import mempool_pkg::*;
();

  logic                               clk = 1'b0;
  logic                               reset;
  tcdm_req_t [NumTiles-1:0]           tile_req;
  logic [NumTiles-1:0]                tile_req_valid;
  logic [NumTiles-1:0]                tile_req_ready;
  logic [NumTiles-1:0][DataWidth-1:0] tile_resp_rdata;
  logic [NumTiles-1:0]                tile_resp_valid;
  dma_req_t                           dma_req;
  logic                               dma_req_valid;
  logic                               dma_req_ready;
  dma_meta_t                          dma_meta;

  // Memory model, pending requests and expected responses per master
  logic [DataWidth-1:0] model_mem [256];
  tcdm_req_t            pend_req [NumTiles][$];
  logic [DataWidth-1:0] pend_exp [NumTiles][$];
  logic [DataWidth-1:0] resp_exp [NumTiles][$];
  int                   resp_cyc [NumTiles][$];
  logic [31:0]          lfsr_state = 32'h43495c4d;
  int                   cycle;
  int                   done_count;
  int                   dma_issued;
  int                   error_count;
  int                   test_errors;
  int                   test_num;
  int                   tests_bad;
  bit                   busy_seen;
  bit                   test_open;
  string                test_name;

  mempool_group dut (
    .clk_i            (clk            ),
    .reset_i          (reset          ),
    .tile_req_i       (tile_req       ),
    .tile_req_valid_i (tile_req_valid ),
    .tile_req_ready_o (tile_req_ready ),
    .tile_resp_rdata_o(tile_resp_rdata),
    .tile_resp_valid_o(tile_resp_valid),
    .dma_req_i        (dma_req        ),
    .dma_req_valid_i  (dma_req_valid  ),
    .dma_req_ready_o  (dma_req_ready  ),
    .dma_meta_o       (dma_meta       )
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle++;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_w,
                                                       input logic [DataWidth-1:0] new_w,
                                                       input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] res;
    res = old_w;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [DataWidth-1:0] got,
                             input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic end_with_failure(input string msg);
    $display("Timeout at %0t ns: %s", $time, msg);
    $display("test failed");
    $finish;
  endtask

  task automatic finish_test();
    if (test_open) begin
      if (test_errors == 0) begin
        $display("Test %0d %s: ok", test_num, test_name);
      end else begin
        $display("Test %0d %s: %0d errors", test_num, test_name, test_errors);
        tests_bad++;
      end
      test_open = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    finish_test();
    test_num++;
    test_name   = name;
    test_errors = 0;
    test_open   = 1'b1;
  endtask

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic idle_gap();
    int n;
    n = 0;
    for (int i = 0; i < 2; i++) begin
      n = 2 * n + int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    repeat (n) @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Tile requests
  // --------------------------------------------------------------------------
  task automatic run_requests();
    int t;
    int left;
    t    = 0;
    left = 1;
    while (left != 0) begin
      @(negedge clk);
      for (int m = 0; m < NumTiles; m++) begin
        tile_req_valid[m] = (pend_req[m].size() != 0);
        if (tile_req_valid[m]) begin
          tile_req[m] = pend_req[m][0];
        end
      end
      #1;
      left = 0;
      for (int m = 0; m < NumTiles; m++) begin
        if (tile_req_valid[m] && tile_req_ready[m]) begin
          if (tile_req[m].write) begin
            model_mem[tile_req[m].addr] = merge_bytes(model_mem[tile_req[m].addr],
                                                      tile_req[m].wdata, tile_req[m].be);
          end else begin
            resp_exp[m].push_back(pend_exp[m][0]);
            resp_cyc[m].push_back(cycle + 1);
          end
          void'(pend_req[m].pop_front());
          void'(pend_exp[m].pop_front());
        end
        left += pend_req[m].size();
      end
      t++;
      if (t > 1000) end_with_failure("tile requests were not accepted");
    end
    @(negedge clk);
    tile_req_valid = '0;
  endtask

  task automatic drain_responses();
    int t;
    int left;
    t    = 0;
    left = 1;
    while (left != 0) begin
      @(negedge clk);
      #1;
      left = 0;
      for (int m = 0; m < NumTiles; m++) begin
        left += resp_exp[m].size();
      end
      t++;
      if (t > 100) end_with_failure("read responses did not arrive");
    end
  endtask

  // --------------------------------------------------------------------------
  // DMA
  // --------------------------------------------------------------------------
  task automatic issue_dma(input logic [7:0] start, input logic [8:0] len,
                           input logic [31:0] value, input bit expect_wait);
    int t;
    bit saw_low;
    bit accepted;
    t        = 0;
    saw_low  = 1'b0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      dma_req       = '{start_addr: start, len: len, value: value};
      dma_req_valid = 1'b1;
      #1;
      if (dma_req_ready) begin
        accepted = 1'b1;
      end else begin
        saw_low = 1'b1;
      end
      t++;
      if (t > 2000) end_with_failure("DMA request was not accepted");
    end
    @(negedge clk);
    dma_req_valid = 1'b0;
    // Later bursts overwrite earlier ones
    for (int k = 0; k < int'(len); k++) begin
      model_mem[8'(int'(start) + k)] = value + DataWidth'(k);
    end
    dma_issued++;
    if (expect_wait && !saw_low) begin
      report_failure("DMA request ready stayed high while a burst was pending");
    end
  endtask

  task automatic wait_dma_done();
    int t;
    t = 0;
    while (done_count < dma_issued) begin
      @(negedge clk);
      #1;
      t++;
      if (t > 2000) end_with_failure("DMA burst did not complete");
    end
    t = 0;
    while (!dma_meta.backend_idle) begin
      @(negedge clk);
      #1;
      t++;
      if (t > 100) end_with_failure("DMA backend did not return to idle");
    end
    check_value("trans_complete pulse count", DataWidth'(done_count), DataWidth'(dma_issued));
    if (!busy_seen) report_failure("backend_idle never went low during the burst");
    busy_seen = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Monitors
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (!reset) begin
      if (dma_meta.trans_complete) done_count++;
      if (!dma_meta.backend_idle) busy_seen = 1'b1;
      for (int m = 0; m < NumTiles; m++) begin
        if (tile_resp_valid[m]) begin
          if (resp_exp[m].size() == 0) begin
            report_failure($sformatf("master %0d got a response with no read pending", m));
          end else begin
            check_value($sformatf("tile_resp_rdata_o[%0d]", m), tile_resp_rdata[m],
                        resp_exp[m][0]);
            if (resp_cyc[m][0] != cycle) begin
              report_failure($sformatf("master %0d read response came at the wrong cycle", m));
            end
            void'(resp_exp[m].pop_front());
            void'(resp_cyc[m].pop_front());
          end
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Golden file commands
  // --------------------------------------------------------------------------
  task automatic execute_line(input string line);
    string       tok;
    string       name;
    logic [31:0] fld [5];
    tcdm_req_t   req;
    logic [7:0]  addr;
    void'($sscanf(line, "%s %h %h %h %h %h", tok, fld[0], fld[1], fld[2], fld[3], fld[4]));
    if (tok == "T") begin
      void'($sscanf(line, "%s %s", tok, name));
      start_test(name);
    end else if (tok == "W") begin
      idle_gap();
      req = '{addr: fld[1][7:0], write: 1'b1, wdata: fld[2], be: fld[3][3:0]};
      pend_req[fld[0][1:0]].push_back(req);
      pend_exp[fld[0][1:0]].push_back('0);
      run_requests();
    end else if (tok == "R") begin
      idle_gap();
      addr = fld[1][7:0];
      check_value($sformatf("model_mem[%h]", addr), model_mem[addr], fld[2]);
      req = '{addr: addr, write: 1'b0, wdata: '0, be: '0};
      pend_req[fld[0][1:0]].push_back(req);
      pend_exp[fld[0][1:0]].push_back(fld[2]);
      run_requests();
      drain_responses();
    end else if (tok == "P") begin
      for (int m = 0; m < NumTiles; m++) begin
        for (int i = 0; i < int'(fld[4]); i++) begin
          addr = fld[m][7:0] + 8'(i);
          req  = '{addr: addr, write: 1'b0, wdata: '0, be: '0};
          pend_req[m].push_back(req);
          pend_exp[m].push_back(model_mem[addr]);
        end
      end
      run_requests();
      drain_responses();
    end else if (tok == "D") begin
      issue_dma(fld[0][7:0], fld[1][8:0], fld[2], fld[3][0]);
    end else if (tok == "C") begin
      wait_dma_done();
    end else begin
      report_failure($sformatf("unknown golden command %s", tok));
    end
  endtask

  initial begin
    int    fd;
    string line;
    reset          = 1'b1;
    tile_req       = '0;
    tile_req_valid = '0;
    dma_req        = '0;
    dma_req_valid  = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    start_test("reset_state");
    @(negedge clk);
    #1;
    check_value("tile_resp_valid_o", DataWidth'(tile_resp_valid), '0);
    check_value("trans_complete", DataWidth'(dma_meta.trans_complete), '0);
    check_value("backend_idle", DataWidth'(dma_meta.backend_idle), 1);
    check_value("dma_req_ready_o", DataWidth'(dma_req_ready), 1);

    fd = $fopen("group_golden.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open group_golden.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          execute_line(line);
        end
      end
      $fclose(fd);
    end
    finish_test();

    // Concurrent assertion failures of the bound checker
    error_count += int'(dut.i_properties.fail_count);

    $display("Tests run: %0d, with errors: %0d, check errors: %0d",
             test_num, tests_bad, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* group_golden.txt */
# T name | W master addr data be | R master addr expected | C wait for DMA completion
# P addr0 addr1 addr2 addr3 count | D start len value expect_ready_low (all hex)
T partial_be
W 0 05 11223344 f
W 0 05 aabbccdd 5
R 0 05 11bb33dd
R 2 05 11bb33dd
T parallel_reads
W 1 10 a0000010 f
W 2 11 a0000011 f
W 3 12 a0000012 f
W 0 13 a0000013 f
W 1 14 a0000014 f
W 2 15 a0000015 f
W 3 16 a0000016 f
W 0 17 a0000017 f
P 10 10 11 14 4
R 3 16 a0000016
T dma_unaligned
W 0 20 cafe0020 f
W 1 2b cafe002b f
D 21 00a 00000100 0
C
R 2 21 00000100
R 3 2a 00000109
R 0 20 cafe0020
R 1 2b cafe002b
P 20 23 26 29 3
T dma_back_to_back
D 40 020 00001000 0
D 50 010 00002000 1
C
R 0 4f 0000100f
R 1 50 00002000
R 2 5f 0000200f
R 3 40 00001000
P 40 48 50 58 8
T dma_with_writes
D fa 009 00003000 0
W 1 60 beef0060 f
W 2 61 beef0061 f
W 3 62 beef0062 f
W 0 63 beef0063 f
C
R 0 fa 00003000
R 1 02 00003008
R 2 ff 00003005
R 3 63 beef0063
P fc fe 00 60 2

/* files.f */
mempool_pkg.sv
tcdm_bank.sv
tcdm_local_xbar.sv
dma_tile_engine.sv
dma_midend.sv
mempool_group.sv
mempool_group_properties.sv
tb_mempool_group.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MemPool group testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mempool_group -f files.f \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "test passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
